/* logic/pixel_pkg.sv */
`default_nettype none

package pixel_pkg;

    localparam int FRAME_W      = 16;
    localparam int FRAME_H      = 16;
    localparam int BLK          = 4;    // Block edge in pixels
    localparam int BLKS_PER_ROW = 4;
    localparam int NBR_DEFAULT  = 128;  // Stand-in for a neighbor outside the frame

    typedef logic [7:0] pixel_t;
    typedef logic [7:0] pix_addr_t;     // Row * FRAME_W + column
    typedef logic [$clog2(BLKS_PER_ROW * BLKS_PER_ROW)-1:0] blk_idx_t; // {row, col}
    typedef logic signed [8:0] residual_t;
    typedef logic [4:0] slot_t;         // Fetch slot number

    // Fetch slots: block pixels, then top row, then left column
    localparam slot_t SLOT_TOP  = slot_t'(BLK * BLK);
    localparam slot_t SLOT_LEFT = slot_t'(BLK * BLK + BLK);
    localparam slot_t N_SLOTS   = slot_t'(BLK * BLK + 2 * BLK);

    typedef enum logic [1:0] {
        PRED_VERT  = 2'd0,
        PRED_HORIZ = 2'd1,
        PRED_DC    = 2'd2
    } pred_mode_t;

    typedef struct packed {
        logic      valid;
        pix_addr_t addr;
        pixel_t    data;
    } pix_wr_t;

    typedef struct packed {
        logic       valid;
        blk_idx_t   blk;
        pred_mode_t mode;
    } fetch_cmd_t;

    typedef struct packed {
        pixel_t [BLK*BLK-1:0] pix;  // Raster order inside the block
        pixel_t [BLK-1:0]     top;
        pixel_t [BLK-1:0]     left;
        pred_mode_t           mode;
        blk_idx_t             blk;
    } nbr_block_t;

    typedef struct packed {
        residual_t [BLK*BLK-1:0] data;
        blk_idx_t                blk;
    } res_bundle_t;

    typedef struct packed {
        residual_t data;
        logic      last;
        blk_idx_t  blk;
    } res_beat_t;

endpackage

`default_nettype wire

/* logic/apb_pkg.sv */
`default_nettype none

package apb_pkg;

    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef struct packed {
        apb_addr_t paddr;
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // Register map
    localparam apb_addr_t ADDR_PIX_BASE = 12'h000;  // 0x000..0x0FF, one pixel per word
    localparam apb_addr_t ADDR_CTRL     = 12'h100;
    localparam apb_addr_t ADDR_STATUS   = 12'h104;

    localparam int CTRL_BLK_LSB   = 0;
    localparam int CTRL_MODE_LSB  = 4;
    localparam int CTRL_START_BIT = 8;

    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_PEND_BIT  = 1;
    localparam int STAT_DONE_LSB  = 8;

endpackage

`default_nettype wire

/* logic/apb_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_regfile import pixel_pkg::*, apb_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  apb_req_t   apb_req,
    output apb_rsp_t   apb_rsp,
    output pix_wr_t    pix_wr,
    output fetch_cmd_t fetch_cmd,
    input  logic       fetch_busy,
    input  logic       out_pending,
    input  logic       beat_done
);

    logic       access;
    logic       wr_acc;
    logic       rd_acc;
    logic       pix_hit;
    logic       ctrl_hit;
    logic       stat_hit;
    logic       start_req;
    logic       start_bad;
    logic [7:0] blocks_done;
    apb_data_t  status_word;

    assign access = apb_req.psel && apb_req.penable; // Access phase, never waits
    assign wr_acc = access && apb_req.pwrite;
    assign rd_acc = access && !apb_req.pwrite;

    assign pix_hit  = apb_req.paddr[11:8] == ADDR_PIX_BASE[11:8];
    assign ctrl_hit = apb_req.paddr == ADDR_CTRL;
    assign stat_hit = apb_req.paddr == ADDR_STATUS;

    assign start_req = wr_acc && ctrl_hit && apb_req.pwdata[CTRL_START_BIT];
    // Mode 3 has no predictor, and a second block cannot queue behind the fetcher
    assign start_bad = fetch_busy || (apb_req.pwdata[CTRL_MODE_LSB +: 2] == 2'd3);

    always_comb begin
        pix_wr.valid = wr_acc && pix_hit;
        pix_wr.addr  = pix_addr_t'(apb_req.paddr[7:0]);
        pix_wr.data  = pixel_t'(apb_req.pwdata[7:0]);
    end

    // Single-cycle start pulse during the access phase
    always_comb begin
        fetch_cmd.valid = start_req && !start_bad;
        fetch_cmd.blk   = blk_idx_t'(apb_req.pwdata[CTRL_BLK_LSB +: 4]);
        fetch_cmd.mode  = pred_mode_t'(apb_req.pwdata[CTRL_MODE_LSB +: 2]);
    end

    always_comb begin
        status_word = '0;
        status_word[STAT_BUSY_BIT] = fetch_busy;
        status_word[STAT_PEND_BIT] = out_pending;
        status_word[STAT_DONE_LSB +: 8] = blocks_done;
    end

    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.prdata  = (rd_acc && stat_hit) ? status_word : '0; // Pixels and CTRL read 0
        apb_rsp.pslverr = (access && !(pix_hit || ctrl_hit || stat_hit))
                        || (start_req && start_bad);
    end

    // Completed blocks, wraps at 256
    always_ff @(posedge clk) begin
        if (rst) begin
            blocks_done <= '0;
        end else if (beat_done) begin
            blocks_done <= blocks_done + 8'd1;
        end
    end

endmodule

`default_nettype wire

/* logic/frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_buffer import pixel_pkg::*; (
    input  logic      clk,
    input  pix_wr_t   pix_wr,
    input  pix_addr_t rd_addr,
    output pixel_t    rd_data
);

    // One luma frame, row-major
    pixel_t mem [FRAME_W*FRAME_H];

    always_ff @(posedge clk) begin
        if (pix_wr.valid) begin
            mem[pix_wr.addr] <= pix_wr.data;
        end
    end

    // Data follows the address by one cycle
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* logic/block_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module block_fetch import pixel_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  fetch_cmd_t fetch_cmd,
    output pix_addr_t  rd_addr,
    input  pixel_t     rd_data,
    output nbr_block_t nbr_blk,
    output logic       blk_valid,
    input  logic       blk_ready,
    output logic       busy
);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        HOLD
    } state_t;

    state_t state;
    slot_t  cnt;        // Next slot to issue
    slot_t  prev;       // Slot whose data is on rd_data
    logic   top_miss;
    logic   left_miss;

    function automatic pix_addr_t slot_addr(blk_idx_t b, slot_t s);
        logic [3:0] r0;
        logic [3:0] c0;
        logic [3:0] r;
        logic [3:0] c;
        r0 = 4'(b[3:2] * BLK);
        c0 = 4'(b[1:0] * BLK);
        if (s < SLOT_TOP) begin
            r = r0 + 4'(s[3:2]);
            c = c0 + 4'(s[1:0]);
        end else if (s < SLOT_LEFT) begin
            r = r0 - 4'd1;              // Row above the block
            c = c0 + 4'(s[1:0]);
        end else begin
            r = r0 + 4'(s[1:0]);
            c = c0 - 4'd1;              // Column left of the block
        end
        return pix_addr_t'(r * FRAME_W + c);
    endfunction

    // Slot 0 goes out in the same cycle as the start pulse
    assign rd_addr = (state == IDLE) ? slot_addr(fetch_cmd.blk, '0) : slot_addr(nbr_blk.blk, cnt);

    assign prev      = cnt - 5'd1;
    assign top_miss  = nbr_blk.blk[3:2] == 2'd0;
    assign left_miss = nbr_blk.blk[1:0] == 2'd0;

    assign blk_valid = state == HOLD;
    assign busy      = state != IDLE;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: if (fetch_cmd.valid) begin
                    cnt   <= 5'd1;
                    state <= READ;
                end
                READ: begin
                    if (cnt == N_SLOTS) begin
                        state <= HOLD;          // Last slot captured this cycle
                    end else begin
                        cnt <= cnt + 5'd1;
                    end
                end
                HOLD: if (blk_ready) begin
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Payload capture, one slot per cycle behind the issue
    always_ff @(posedge clk) begin
        if (state == IDLE && fetch_cmd.valid) begin
            nbr_blk.blk  <= fetch_cmd.blk;
            nbr_blk.mode <= fetch_cmd.mode;
        end
        if (state == READ) begin
            if (prev < SLOT_TOP) begin
                nbr_blk.pix[prev[3:0]] <= rd_data;
            end else if (prev < SLOT_LEFT) begin
                nbr_blk.top[prev[1:0]] <= top_miss ? pixel_t'(NBR_DEFAULT) : rd_data;
            end else begin
                nbr_blk.left[prev[1:0]] <= left_miss ? pixel_t'(NBR_DEFAULT) : rd_data;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/intra_predict.sv */
`timescale 1ns/1ps
`default_nettype none

module intra_predict import pixel_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  nbr_block_t  nbr_blk,
    input  logic        blk_valid,
    output logic        blk_ready,
    output res_bundle_t res,
    output logic        res_valid,
    input  logic        res_ready
);

    res_bundle_t res_next;
    logic [10:0] dc_sum;
    pixel_t      dc_pred;

    // Rounded mean of the 8 neighbors
    always_comb begin
        dc_sum = 11'd4;
        for (int k = 0; k < BLK; k++) begin
            dc_sum = dc_sum + nbr_blk.top[k] + nbr_blk.left[k];
        end
        dc_pred = dc_sum[10:3];
    end

    always_comb begin
        pixel_t pred;
        pred = '0;
        for (int i = 0; i < BLK*BLK; i++) begin
            case (nbr_blk.mode)
                PRED_VERT:  pred = nbr_blk.top[i % BLK];   // Column above
                PRED_HORIZ: pred = nbr_blk.left[i / BLK];  // Row to the left
                default:    pred = dc_pred;
            endcase
            res_next.data[i] = residual_t'({1'b0, nbr_blk.pix[i]} - {1'b0, pred});
        end
        res_next.blk = nbr_blk.blk;
    end

    // Take a new block when empty or when the held one leaves this cycle
    assign blk_ready = !res_valid || res_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (blk_valid && blk_ready) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (blk_valid && blk_ready) begin
            res <= res_next;
        end
    end

endmodule

`default_nettype wire

/* logic/residual_out.sv */
`timescale 1ns/1ps
`default_nettype none

module residual_out import pixel_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  res_bundle_t res,
    input  logic        res_valid,
    output logic        res_ready,
    output res_beat_t   out_beat,
    output logic        out_valid,
    input  logic        out_ready,
    output logic        pending,
    output logic        beat_done
);

    res_bundle_t hold;      // Beat 0 always sits in data[0]
    logic [3:0]  beat_cnt;
    logic        last;

    assign last      = beat_cnt == 4'd15;
    assign res_ready = !pending;            // Whole bundle must drain first
    assign out_valid = pending;
    assign beat_done = out_valid && out_ready && last;

    always_comb begin
        out_beat.data = hold.data[0];
        out_beat.last = last;
        out_beat.blk  = hold.blk;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending  <= 1'b0;
            beat_cnt <= '0;
        end else if (res_valid && res_ready) begin
            pending  <= 1'b1;
            beat_cnt <= '0;
        end else if (out_valid && out_ready) begin
            pending  <= !last;
            beat_cnt <= beat_cnt + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid && res_ready) begin
            hold <= res;
        end else if (out_valid && out_ready) begin
            hold.data <= hold.data >> $bits(residual_t);  // Next beat into slot 0
        end
    end

endmodule

`default_nettype wire

/* logic/intra_top.sv */
`timescale 1ns/1ps
`default_nettype none

module intra_top import pixel_pkg::*, apb_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  apb_req_t  apb_req,
    output apb_rsp_t  apb_rsp,
    output res_beat_t out_beat,
    output logic      out_valid,
    input  logic      out_ready
);

    pix_wr_t     pix_wr;
    fetch_cmd_t  fetch_cmd;
    pix_addr_t   rd_addr;
    pixel_t      rd_data;
    nbr_block_t  nbr_blk;
    logic        blk_valid;
    logic        blk_ready;
    logic        fetch_busy;
    res_bundle_t res;
    logic        res_valid;
    logic        res_ready;
    logic        out_pending;
    logic        beat_done;

    apb_regfile u_regs (
        .clk         (clk),
        .rst         (rst),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .pix_wr      (pix_wr),
        .fetch_cmd   (fetch_cmd),
        .fetch_busy  (fetch_busy),
        .out_pending (out_pending),
        .beat_done   (beat_done)
    );

    frame_buffer u_frame (
        .clk     (clk),
        .pix_wr  (pix_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    block_fetch u_fetch (
        .clk       (clk),
        .rst       (rst),
        .fetch_cmd (fetch_cmd),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .nbr_blk   (nbr_blk),
        .blk_valid (blk_valid),
        .blk_ready (blk_ready),
        .busy      (fetch_busy)
    );

    intra_predict u_pred (
        .clk       (clk),
        .rst       (rst),
        .nbr_blk   (nbr_blk),
        .blk_valid (blk_valid),
        .blk_ready (blk_ready),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

    residual_out u_out (
        .clk       (clk),
        .rst       (rst),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .pending   (out_pending),
        .beat_done (beat_done)
    );

endmodule

`default_nettype wire

/* tb/intra_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module intra_tb import pixel_pkg::*, apb_pkg::*; ();

    localparam int N_TESTS      = 8;
    localparam int FIRST_OUT    = 27;   // Start access phase to first out_valid
    localparam int WATCHDOG_CYC = FRAME_W * FRAME_H * 2 + N_TESTS * (30 + 16 * 4) + 200;

    typedef struct packed {
        blk_idx_t   blk;
        logic [1:0] mode;
        logic       stall;       // Random out_ready
        logic       exp_err;     // pslverr expected on the start write
        logic       busy_retry;  // Second start while the first one fetches
    } test_row_t;

    logic        clk;
    logic        rst;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    res_beat_t   out_beat;
    logic        out_valid;
    logic        out_ready;

    test_row_t   rows [N_TESTS];
    pixel_t      img [FRAME_W*FRAME_H];  // Copy of what was loaded
    int          exp_res [BLK*BLK];
    logic [31:0] lfsr;
    int          err_cnt;
    int          done_exp;

    intra_top intra_top_i (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1 with one new bit per step
    function automatic logic next_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    task automatic check_val(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("FAILED t=%0t %s expected %0d got %0d", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    // Setup and access phase that return 1 ns after the completing edge
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        apb_req.pwrite  = wr;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        #4;
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check_val("pready", 1, apb_rsp.pready);
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    // Reference predictor on the testbench image
    task automatic build_expected(input blk_idx_t blk, input logic [1:0] mode);
        int r0;
        int c0;
        int top [BLK];
        int left [BLK];
        int dc;
        int pred;
        r0 = int'(blk[3:2]) * BLK;
        c0 = int'(blk[1:0]) * BLK;
        dc = 4;
        for (int k = 0; k < BLK; k++) begin
            top[k]  = (r0 == 0) ? NBR_DEFAULT : int'(img[(r0 - 1) * FRAME_W + c0 + k]);
            left[k] = (c0 == 0) ? NBR_DEFAULT : int'(img[(r0 + k) * FRAME_W + c0 - 1]);
            dc = dc + top[k] + left[k];
        end
        dc = dc >> 3;
        for (int i = 0; i < BLK*BLK; i++) begin
            case (mode)
                2'd0:    pred = top[i % BLK];
                2'd1:    pred = left[i / BLK];
                default: pred = dc;
            endcase
            exp_res[i] = int'(img[(r0 + i / BLK) * FRAME_W + c0 + i % BLK]) - pred;
        end
    endtask

    task automatic load_table();
        rows[0] = '{blk: 4'd5,  mode: 2'd0, stall: 1'b0, exp_err: 1'b0, busy_retry: 1'b0};
        rows[1] = '{blk: 4'd5,  mode: 2'd1, stall: 1'b0, exp_err: 1'b0, busy_retry: 1'b0};
        rows[2] = '{blk: 4'd5,  mode: 2'd2, stall: 1'b0, exp_err: 1'b0, busy_retry: 1'b0};
        rows[3] = '{blk: 4'd0,  mode: 2'd2, stall: 1'b1, exp_err: 1'b0, busy_retry: 1'b0};
        rows[4] = '{blk: 4'd3,  mode: 2'd0, stall: 1'b1, exp_err: 1'b0, busy_retry: 1'b0};
        rows[5] = '{blk: 4'd12, mode: 2'd1, stall: 1'b0, exp_err: 1'b0, busy_retry: 1'b1};
        rows[6] = '{blk: 4'd9,  mode: 2'd3, stall: 1'b0, exp_err: 1'b1, busy_retry: 1'b0};
        rows[7] = '{blk: 4'd15, mode: 2'd2, stall: 1'b1, exp_err: 1'b0, busy_retry: 1'b0};
    endtask

    task automatic run_test(input int t, output logic ok);
        test_row_t row;
        apb_data_t ctrl;
        apb_data_t rdata;
        logic      err;
        logic      rdy;
        logic      held;
        res_beat_t held_beat;
        int        got;
        int        cyc;
        int        first_lat;
        int        errs_before;
        row = rows[t];
        errs_before = err_cnt;
        ctrl = '0;
        ctrl[CTRL_BLK_LSB +: 4]  = row.blk;
        ctrl[CTRL_MODE_LSB +: 2] = row.mode;
        ctrl[CTRL_START_BIT]     = 1'b1;
        build_expected(row.blk, row.mode);
        apb_xfer(1'b1, ADDR_CTRL, ctrl, rdata, err);
        check_val("pslverr on start", row.exp_err, err);
        if (row.exp_err) begin
            repeat (FIRST_OUT + 3) begin     // Nothing may come out
                @(posedge clk);
                #1;
                if (out_valid) begin
                    $display("t=%0t out_valid rose after a refused start", $time);
                    err_cnt++;
                end
            end
        end else begin
            cyc = 1;
            if (row.busy_retry) begin
                apb_xfer(1'b0, ADDR_STATUS, '0, rdata, err);
                if (!rdata[STAT_BUSY_BIT]) begin
                    $display("t=%0t STATUS did not show fetch_busy during a fetch", $time);
                    err_cnt++;
                end
                apb_xfer(1'b1, ADDR_CTRL, ctrl, rdata, err);
                check_val("pslverr on start while busy", 1, err);
            end
            got       = 0;
            held      = 1'b0;
            first_lat = 0;
            while (got < BLK*BLK) begin
                rdy = row.stall ? next_bit() : 1'b1;
                out_ready = rdy;
                if (held && !out_valid) begin
                    $display("t=%0t out_valid dropped before beat %0d was taken", $time, got);
                    err_cnt++;
                    held = 1'b0;
                end
                if (out_valid) begin
                    if (first_lat == 0) begin
                        first_lat = cyc;
                    end
                    if (held && out_beat != held_beat) begin
                        $display("FAILED t=%0t out_beat expected %h got %h (changed while stalled)",
                                 $time, held_beat, out_beat);
                        err_cnt++;
                    end
                    if (rdy) begin
                        check_val($sformatf("out_beat.data[%0d]", got), exp_res[got],
                                  $signed(out_beat.data));
                        check_val($sformatf("out_beat.last[%0d]", got), got == BLK*BLK - 1,
                                  out_beat.last);
                        check_val($sformatf("out_beat.blk[%0d]", got), row.blk, out_beat.blk);
                        got++;
                        held = 1'b0;
                    end else begin
                        held      = 1'b1;
                        held_beat = out_beat;
                    end
                end
                @(posedge clk);
                #1;
                cyc++;
            end
            done_exp++;
            if (!row.stall && !row.busy_retry) begin
                check_val("first out_valid latency", FIRST_OUT, first_lat);
            end
        end
        out_ready = 1'b1;
        if (out_valid) begin
            $display("t=%0t out_valid still high after the last beat", $time);
            err_cnt++;
        end
        apb_xfer(1'b0, ADDR_STATUS, '0, rdata, err);
        check_val("STATUS pslverr", 0, err);
        check_val("STATUS.fetch_busy", 0, rdata[STAT_BUSY_BIT]);
        check_val("STATUS.out_pending", 0, rdata[STAT_PEND_BIT]);
        check_val("STATUS.blocks_done", done_exp, rdata[STAT_DONE_LSB +: 8]);
        ok = (err_cnt == errs_before);
        $display("test %0d blk %0d mode %0d stall %0d: %s", t, row.blk, row.mode, row.stall,
                 ok ? "ok" : "errors");
    endtask

    initial begin
        apb_data_t rdata;
        logic      err;
        logic      ok;
        pixel_t    px;
        int        fails;
        rst       = 1'b1;
        apb_req   = '0;
        out_ready = 1'b0;
        lfsr      = 32'hbcfc;
        err_cnt   = 0;
        done_exp  = 0;
        fails     = 0;
        load_table();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // Image load with 8 LFSR bits per pixel
        for (int p = 0; p < FRAME_W*FRAME_H; p++) begin
            px = '0;
            for (int k = 0; k < 8; k++) begin
                px = {px[6:0], next_bit()};
            end
            img[p] = px;
            apb_xfer(1'b1, ADDR_PIX_BASE + apb_addr_t'(p), apb_data_t'(px), rdata, err);
            check_val($sformatf("pslverr on pixel write %0d", p), 0, err);
        end

        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t, ok);
            if (!ok) begin
                fails++;
            end
        end

        $display("%0d tests, %0d passed, %0d failed, %0d failed checks",
                 N_TESTS, N_TESTS - fails, fails, err_cnt);
        if (fails == 0 && err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYC * 10);
        $display("Timeout: the tests did not complete within %0d cycles", WATCHDOG_CYC);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
logic/pixel_pkg.sv
logic/apb_pkg.sv
logic/apb_regfile.sv
logic/frame_buffer.sv
logic/block_fetch.sv
logic/intra_predict.sv
logic/residual_out.sv
logic/intra_top.sv
tb/intra_tb.sv

/* Bender.yml */
package:
  name: intra_pred

sources:
  - logic/pixel_pkg.sv
  - logic/apb_pkg.sv
  - logic/apb_regfile.sv
  - logic/frame_buffer.sv
  - logic/block_fetch.sv
  - logic/intra_predict.sv
  - logic/residual_out.sv
  - logic/intra_top.sv
  - target: test
    files:
      - tb/intra_tb.sv
